// ==== files.f ====
+incdir+verification
src/cpu_pkg.sv
src/mem_bus_if.sv
src/inst_decoder.sv
src/regfile.sv
src/fetch_unit.sv
src/issue_unit.sv
src/mem_arbiter.sv
src/cpu_top.sv
verification/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: dual_issue_core

sources:
  - src/cpu_pkg.sv
  - src/mem_bus_if.sv
  - src/inst_decoder.sv
  - src/regfile.sv
  - src/fetch_unit.sv
  - src/issue_unit.sv
  - src/mem_arbiter.sv
  - src/cpu_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_cpu.sv

// ==== verification/cpu_ref_model.svh ====
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// segment 0x8 drops to 0x0, segment 0xB drops to 0x1
function automatic word_t phys_of(word_t va);
	if (va[31:28] == 4'h8) begin
		return va - 32'h8000_0000;
	end
	if (va[31:28] == 4'hB) begin
		return va - 32'hA000_0000;
	end
	return va;
endfunction

function automatic word_t rtype_word(logic [5:0] fn, int rd, int rs, int rt, int sh);
	return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic word_t itype_word(logic [5:0] op, int rt, int rs, int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

// sw of each register to 4*r off the r1 base
function automatic void add_stores(int lo, int hi);
	for (int r = lo; r <= hi; r++) begin
		prog.push_back(itype_word(OP_SW, r, 1, 4 * r));
	end
endfunction

function automatic word_t random_inst();
	logic [5:0] rfn [8];
	logic [5:0] iop [6];
	int kind;
	int d;
	int s;
	int t;
	int imm;
	rfn = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL, FN_SRL};
	iop = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	kind = $urandom_range(17, 0);
	// r1 stays the data base, r0 still shows up as a target
	d = $urandom_range(10, 2) % 10;
	s = $urandom_range(9, 0);
	t = $urandom_range(9, 0);
	imm = $urandom_range(16'hFFFF, 0);
	if (kind < 6) begin
		return rtype_word(rfn[kind], d, s, t, 0);
	end
	if (kind < 8) begin
		return rtype_word(rfn[kind], d, 0, t, imm % 32);
	end
	if (kind < 14) begin
		return itype_word(iop[kind - 8], d, s, imm);
	end
	// small window so loads tend to hit earlier stores
	if (kind < 16) begin
		return itype_word(OP_LW, d, 1, 4 * (imm % 16));
	end
	return itype_word(OP_SW, t, 1, 4 * (imm % 16));
endfunction

function automatic void build_program(int t);
	prog.delete();
	prog.push_back(itype_word(OP_LUI, 1, 0, 16'h8000));
	case (t)
		1: begin
			prog.push_back(itype_word(OP_ADDIU, 2, 0, -5));
			prog.push_back(itype_word(OP_ADDIU, 3, 0, 7));
			prog.push_back(rtype_word(FN_ADDU, 4, 2, 3, 0));
			prog.push_back(rtype_word(FN_SUBU, 5, 2, 3, 0));
			prog.push_back(rtype_word(FN_AND, 6, 2, 3, 0));
			prog.push_back(rtype_word(FN_OR, 7, 2, 3, 0));
			prog.push_back(rtype_word(FN_XOR, 8, 2, 3, 0));
			prog.push_back(rtype_word(FN_SLT, 9, 2, 3, 0));
			prog.push_back(rtype_word(FN_SLT, 10, 3, 2, 0));
			prog.push_back(rtype_word(FN_SLL, 11, 0, 3, 4));
			prog.push_back(rtype_word(FN_SRL, 12, 0, 2, 3));
			add_stores(4, 12);
		end
		2: begin
			prog.push_back(itype_word(OP_ADDIU, 2, 0, -100));
			prog.push_back(itype_word(OP_SLTI, 3, 2, -50));
			prog.push_back(itype_word(OP_SLTI, 4, 2, -200));
			prog.push_back(itype_word(OP_ANDI, 5, 2, 16'hF0F0));
			prog.push_back(itype_word(OP_ORI, 6, 0, 16'h8001));
			prog.push_back(itype_word(OP_XORI, 7, 2, 16'hFFFF));
			prog.push_back(itype_word(OP_LUI, 8, 0, 16'h1234));
			prog.push_back(itype_word(OP_ORI, 8, 8, 16'h5678));
			prog.push_back(itype_word(OP_ADDIU, 9, 0, 16'h8000));
			add_stores(3, 9);
		end
		3: begin
			prog.push_back(itype_word(OP_ADDIU, 2, 0, 3));
			prog.push_back(rtype_word(FN_ADDU, 3, 2, 2, 0));
			prog.push_back(itype_word(OP_ADDIU, 4, 0, 1));
			prog.push_back(itype_word(OP_ADDIU, 4, 0, 2));
			prog.push_back(itype_word(OP_ADDIU, 0, 0, 9));
			prog.push_back(rtype_word(FN_ADDU, 5, 0, 2, 0));
			prog.push_back(itype_word(OP_ADDIU, 6, 0, 10));
			prog.push_back(itype_word(OP_ADDIU, 7, 0, 20));
			prog.push_back(rtype_word(FN_SUBU, 8, 7, 6, 0));
			prog.push_back(rtype_word(FN_ADDU, 8, 8, 8, 0));
			prog.push_back(itype_word(OP_ADDIU, 9, 4, 0));
			add_stores(0, 9);
		end
		4: begin
			prog.push_back(itype_word(OP_ADDIU, 2, 0, 16'h55));
			prog.push_back(itype_word(OP_SW, 2, 1, 16'h40));
			prog.push_back(itype_word(OP_LW, 3, 1, 16'h40));
			prog.push_back(rtype_word(FN_ADDU, 4, 3, 3, 0));
			prog.push_back(itype_word(OP_SW, 4, 1, 16'h44));
			prog.push_back(itype_word(OP_LW, 5, 1, 16'h44));
			prog.push_back(itype_word(OP_SW, 5, 1, 16'h48));
		end
		5: begin
			prog.push_back(itype_word(OP_LUI, 2, 0, 16'hB000));
			prog.push_back(itype_word(OP_LUI, 3, 0, 16'h2000));
			prog.push_back(itype_word(OP_ADDIU, 4, 0, 16'h11));
			prog.push_back(itype_word(OP_SW, 4, 1, 16'h10));
			prog.push_back(itype_word(OP_SW, 4, 2, 16'h20));
			prog.push_back(itype_word(OP_SW, 4, 3, 16'h30));
			// lands in segment 0xA, which is not remapped
			prog.push_back(itype_word(OP_SW, 4, 2, -4));
		end
		default: begin
			repeat (59) prog.push_back(random_inst());
			add_stores(2, 9);
		end
	endcase
endfunction

`endif

// ==== verification/tb_cpu.sv ====
module tb_cpu
	import cpu_pkg::*;
();

	localparam int NUM_TESTS = 6;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLES_PER_INST = 40;
	localparam int SEED = 76973;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic mem_req;
	logic mem_we;
	word_t mem_addr;
	word_t mem_wdata;
	logic mem_ack;
	word_t mem_rdata;

	word_t mem [word_t];
	word_t prog [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	logic rand_delay = 1'b0;
	int store_idx = 0;
	int test_errors = 0;
	int watch_cycles = 0;
	string names [1:6] = '{"alu_rtype", "alu_imm", "pairs", "store_load", "addr_map", "random"};

	`include "cpu_ref_model.svh"

	// in-order ISA model, collects the expected stores
	function automatic void run_reference();
		word_t regs [32];
		word_t dmem [word_t];
		word_t ins;
		word_t a;
		word_t b;
		word_t imm_s;
		word_t res;
		word_t pa;
		logic [4:0] dst;
		logic wr;
		exp_addr.delete();
		exp_data.delete();
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		foreach (prog[i]) begin
			dmem[phys_of(RESET_PC + 32'(4 * i))] = prog[i];
		end
		foreach (prog[i]) begin
			ins = prog[i];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			pa = phys_of(a + imm_s);
			dst = ins[20:16];
			wr = 1'b1;
			res = '0;
			case (ins[31:26])
				OP_SPECIAL: begin
					dst = ins[15:11];
					case (ins[5:0])
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND: res = a & b;
						FN_OR: res = a | b;
						FN_XOR: res = a ^ b;
						FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL: res = b << ins[10:6];
						FN_SRL: res = b >> ins[10:6];
						default: wr = 1'b0;
					endcase
				end
				OP_ADDIU: res = a + imm_s;
				OP_SLTI: res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
				OP_ANDI: res = a & {16'h0, ins[15:0]};
				OP_ORI: res = a | {16'h0, ins[15:0]};
				OP_XORI: res = a ^ {16'h0, ins[15:0]};
				OP_LUI: res = {ins[15:0], 16'h0};
				OP_LW: res = dmem.exists(pa) ? dmem[pa] : '0;
				OP_SW: begin
					dmem[pa] = b;
					exp_addr.push_back(pa);
					exp_data.push_back(b);
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) begin
				regs[dst] = res;
			end
		end
	endfunction

	always #4 clk = ~clk;

	cpu_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	task automatic check_store_addr(input int idx, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH mem_addr store %0d: expected %h got %h", idx, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_store_data(input int idx, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("MISMATCH mem_wdata store %0d: expected %h got %h", idx, expected, actual);
			test_errors++;
		end
	endtask

	// four-phase slave, answers on the falling edge
	initial begin : memory_model
		int delay;
		mem_ack = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				mem_ack = 1'b0;
			end else if (mem_req && !mem_ack) begin
				delay = rand_delay ? $urandom_range(3, 0) : 0;
				repeat (delay) @(negedge clk);
				if (rst_n) begin
					if (mem_we) begin
						mem[mem_addr] = mem_wdata;
					end else begin
						mem_rdata = mem.exists(mem_addr) ? mem[mem_addr] : '0;
					end
					mem_ack = 1'b1;
				end
			end else if (mem_ack && !mem_req) begin
				mem_ack = 1'b0;
			end
		end
	end

	// one posedge sees req and ack both high per handshake
	always @(posedge clk) begin
		if (rst_n && mem_req && mem_ack && mem_we) begin
			if (store_idx < exp_addr.size()) begin
				check_store_addr(store_idx, exp_addr[store_idx], mem_addr);
				check_store_data(store_idx, exp_data[store_idx], mem_wdata);
			end else begin
				$display("unexpected extra store to %h after the last expected one", mem_addr);
				test_errors++;
			end
			store_idx++;
		end
	end

	task automatic run_test(input int t);
		int limit;
		int cyc;
		rst_n = 1'b0;
		rand_delay = (t == NUM_TESTS);
		test_errors = 0;
		build_program(t);
		mem.delete();
		foreach (prog[i]) begin
			mem[phys_of(RESET_PC + 32'(4 * i))] = prog[i];
		end
		run_reference();
		store_idx = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		limit = prog.size() * CYCLES_PER_INST;
		cyc = 0;
		while (store_idx < exp_addr.size() && cyc < limit) begin
			@(negedge clk);
			cyc++;
		end
		if (store_idx < exp_addr.size()) begin
			$display("test %0d: %0d expected stores never reached the memory port",
				t, exp_addr.size() - store_idx);
			test_errors++;
		end
		$display("test %0d %s: %s, %0d of %0d stores seen", t, names[t],
			(test_errors == 0) ? "ok" : "FAIL", store_idx, exp_addr.size());
	endtask

	initial begin : run_all
		int total;
		int ok_count;
		int total_errors;
		void'($urandom(SEED));
		total = 0;
		for (int t = 1; t <= NUM_TESTS; t++) begin
			build_program(t);
			total += prog.size();
		end
		watch_cycles = total * CYCLES_PER_INST + NUM_TESTS * (RESET_CYCLES + 4);
		ok_count = 0;
		total_errors = 0;
		@(negedge clk);
		for (int t = 1; t <= NUM_TESTS; t++) begin
			run_test(t);
			total_errors += test_errors;
			if (test_errors == 0) begin
				ok_count++;
			end
		end
		$display("%0d of %0d tests ok, %0d errors", ok_count, NUM_TESTS, total_errors);
		if (total_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (watch_cycles != 0);
		repeat (watch_cycles) @(posedge clk);
		$display("timeout: run still busy after %0d cycles", watch_cycles);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== src/cpu_top.sv ====
module cpu_top
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	output logic mem_req,
	output logic mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input logic mem_ack,
	input word_t mem_rdata
);

	inst_entry_t head0;
	inst_entry_t head1;
	logic [2:0] count;
	logic [1:0] pop_count;

	mem_bus_if fetch_bus ();
	mem_bus_if data_bus ();

	fetch_unit u_fetch_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus       (fetch_bus.master),
		.head0     (head0),
		.head1     (head1),
		.count     (count),
		.pop_count (pop_count)
	);

	issue_unit u_issue_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.head0     (head0),
		.head1     (head1),
		.count     (count),
		.pop_count (pop_count),
		.bus       (data_bus.master)
	);

	// single external port shared by fetch and data
	mem_arbiter u_mem_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.fetch_bus (fetch_bus.slave),
		.data_bus  (data_bus.slave),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

endmodule

// ==== src/mem_arbiter.sv ====
module mem_arbiter
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	mem_bus_if.slave fetch_bus,
	mem_bus_if.slave data_bus,
	output logic mem_req,
	output logic mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input logic mem_ack,
	input word_t mem_rdata
);

	typedef enum logic [1:0] {GNT_IDLE, GNT_FETCH, GNT_DATA} gnt_e;

	gnt_e gnt;
	gnt_e sel;
	gnt_e gnt_next;
	logic sel_req;

	// idle port picks straight away, data first
	always_comb begin
		sel = gnt;
		if (gnt == GNT_IDLE) begin
			if (data_bus.req) begin
				sel = GNT_DATA;
			end else if (fetch_bus.req) begin
				sel = GNT_FETCH;
			end
		end
	end

	assign sel_req = (sel == GNT_DATA) ? data_bus.req :
		(sel == GNT_FETCH) ? fetch_bus.req : 1'b0;

	// released once req and ack are both back low
	assign gnt_next = (sel != GNT_IDLE && !sel_req && !mem_ack) ? GNT_IDLE : sel;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt <= GNT_IDLE;
		end else begin
			gnt <= gnt_next;
		end
	end

	assign mem_req = sel_req;
	assign mem_we = (sel == GNT_DATA) ? data_bus.we : (sel == GNT_FETCH) && fetch_bus.we;
	assign mem_addr = (sel == GNT_DATA) ? data_bus.addr : fetch_bus.addr;
	assign mem_wdata = (sel == GNT_DATA) ? data_bus.wdata : fetch_bus.wdata;

	assign fetch_bus.ack = (sel == GNT_FETCH) && mem_ack;
	assign fetch_bus.rdata = (sel == GNT_FETCH) ? mem_rdata : '0;
	assign data_bus.ack = (sel == GNT_DATA) && mem_ack;
	assign data_bus.rdata = (sel == GNT_DATA) ? mem_rdata : '0;

	// an ack from memory always has a granted master to go to
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_ack |-> sel != GNT_IDLE);

endmodule

// ==== src/issue_unit.sv ====
module issue_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input inst_entry_t head0,
	input inst_entry_t head1,
	input logic [2:0] count,
	output logic [1:0] pop_count,
	mem_bus_if.master bus
);

	decoded_t dec_m;
	decoded_t dec_s;
	word_t rs_m;
	word_t rt_m;
	word_t rs_s;
	word_t rt_s;
	word_t res_m;
	word_t res_s;
	word_t wd0;
	logic wen0;
	logic wen1;
	logic m_mem;
	logic s_mem;
	logic raw;
	logic issue_m;
	logic issue_s;
	logic start_mem;
	logic mem_done;
	logic req;

	// operand select and execute for one slot
	function automatic word_t exec_dec(decoded_t d, word_t rs_v, word_t rt_v);
		word_t a;
		word_t b;
		a = (d.alu_op == ALU_SLL || d.alu_op == ALU_SRL) ? word_t'(d.shamt) : rs_v;
		b = d.use_imm ? d.imm_value : rt_v;
		return alu_exec(d.alu_op, a, b);
	endfunction

	inst_decoder u_dec_master (
		.inst (head0.inst),
		.dec  (dec_m)
	);

	inst_decoder u_dec_slave (
		.inst (head1.inst),
		.dec  (dec_s)
	);

	regfile u_regfile (
		.clk   (clk),
		.rst_n (rst_n),
		.ra0   (dec_m.rs),
		.ra1   (dec_m.rt),
		.ra2   (dec_s.rs),
		.ra3   (dec_s.rt),
		.rd0   (rs_m),
		.rd1   (rt_m),
		.rd2   (rs_s),
		.rd3   (rt_s),
		.wen0  (wen0),
		.wen1  (wen1),
		.wa0   (dec_m.dest),
		.wa1   (dec_s.dest),
		.wd0   (wd0),
		.wd1   (res_s)
	);

	assign res_m = exec_dec(dec_m, rs_m, rt_m);
	assign res_s = exec_dec(dec_s, rs_s, rt_s);

	assign m_mem = dec_m.is_load || dec_m.is_store;
	assign s_mem = dec_s.is_load || dec_s.is_store;
	// slave reads what the master writes this cycle
	assign raw = dec_m.reg_wen && (dec_s.rs == dec_m.dest || dec_s.rt == dec_m.dest);

	assign issue_m = (count != 3'd0) && !m_mem && !req;
	assign issue_s = issue_m && (count >= 3'd2) && !s_mem && !raw;
	// previous handshake must be fully back to low
	assign start_mem = (count != 3'd0) && m_mem && !req && !bus.ack;
	assign mem_done = req && bus.ack;

	always_comb begin
		pop_count = 2'd0;
		if (mem_done) begin
			pop_count = 2'd1;
		end else if (issue_m) begin
			pop_count = issue_s ? 2'd2 : 2'd1;
		end
	end

	// load data shares port 0 with the master ALU result
	assign wen0 = dec_m.reg_wen && (issue_m || (mem_done && dec_m.is_load));
	assign wd0 = mem_done ? bus.rdata : res_m;
	assign wen1 = issue_s && dec_s.reg_wen;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
		end else if (start_mem) begin
			req <= 1'b1;
		end else if (mem_done) begin
			req <= 1'b0;
		end
	end

	// head0 and the regfile hold still while req is up
	assign bus.req = req;
	assign bus.we = dec_m.is_store;
	assign bus.addr = map_addr(res_m);
	assign bus.wdata = rt_m;

	// address and store data hold while the request waits for ack
	assert property (@(posedge clk) disable iff (!rst_n)
		req && !bus.ack |=> $stable(bus.addr) && $stable(bus.we) && $stable(bus.wdata));

	// queue presents the pair in program order
	assert property (@(posedge clk) disable iff (!rst_n)
		count >= 3'd2 |-> head1.pc == head0.pc + 32'd4);

endmodule

// ==== src/fetch_unit.sv ====
module fetch_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	mem_bus_if.master bus,
	output inst_entry_t head0,
	output inst_entry_t head1,
	output logic [2:0] count,
	input logic [1:0] pop_count
);

	inst_entry_t queue [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [2:0] cnt;
	word_t pc;
	logic req;
	logic push;
	logic start;

	// one fetch in flight at most, so a free slot is enough
	assign start = !req && !bus.ack && (cnt < FIFO_DEPTH);
	assign push = req && bus.ack;

	assign bus.req = req;
	assign bus.we = 1'b0;
	assign bus.addr = map_addr(pc);
	assign bus.wdata = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
			pc <= RESET_PC;
		end else begin
			if (push) begin
				req <= 1'b0;
				pc <= pc + 32'd4;
			end else if (start) begin
				req <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			rd_ptr <= rd_ptr + pop_count;
			cnt <= cnt + 3'(push) - 3'(pop_count);
		end
	end

	// queue payload
	always_ff @(posedge clk) begin
		if (push) begin
			queue[wr_ptr] <= '{inst: bus.rdata, pc: pc};
		end
	end

	assign head0 = queue[rd_ptr];
	assign head1 = queue[rd_ptr + 1'b1];
	assign count = cnt;

	// request held until the arbiter passes ack back
	assert property (@(posedge clk) disable iff (!rst_n) req && !bus.ack |=> req);

	// a wrapped difference also catches issue popping more than it sees
	assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (cnt - 3'(pop_count)) < FIFO_DEPTH);

endmodule

// ==== src/regfile.sv ====
module regfile
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input reg_addr_t ra0,
	input reg_addr_t ra1,
	input reg_addr_t ra2,
	input reg_addr_t ra3,
	output word_t rd0,
	output word_t rd1,
	output word_t rd2,
	output word_t rd3,
	input logic wen0,
	input logic wen1,
	input reg_addr_t wa0,
	input reg_addr_t wa1,
	input word_t wd0,
	input word_t wd1
);

	word_t regs [32];

	// port 1 last, so the slave wins on a shared destination
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wen0) begin
				regs[wa0] <= wd0;
			end
			if (wen1) begin
				regs[wa1] <= wd1;
			end
		end
	end

	// r0 reads as zero
	assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];
	assign rd3 = (ra3 == '0) ? '0 : regs[ra3];

	// decoders drop writes to r0
	assert property (@(posedge clk) disable iff (!rst_n)
		(wen0 |-> wa0 != '0) and (wen1 |-> wa1 != '0));

endmodule

// ==== src/inst_decoder.sv ====
module inst_decoder
	import cpu_pkg::*;
(
	input word_t inst,
	output decoded_t dec
);

	logic writes;

	always_comb begin
		dec = '0;
		dec.rs = inst[25:21];
		dec.rt = inst[20:16];
		dec.shamt = inst[10:6];
		// I-type defaults
		dec.dest = inst[20:16];
		dec.use_imm = 1'b1;
		dec.imm_value = {{16{inst[15]}}, inst[15:0]};
		dec.alu_op = ALU_NOP;
		writes = 1'b1;
		case (inst[31:26])
			OP_SPECIAL: begin
				dec.dest = inst[15:11];
				dec.use_imm = 1'b0;
				case (inst[5:0])
					FN_ADDU: dec.alu_op = ALU_ADD;
					FN_SUBU: dec.alu_op = ALU_SUB;
					FN_AND: dec.alu_op = ALU_AND;
					FN_OR: dec.alu_op = ALU_OR;
					FN_XOR: dec.alu_op = ALU_XOR;
					FN_SLT: dec.alu_op = ALU_SLT;
					FN_SLL: dec.alu_op = ALU_SLL;
					FN_SRL: dec.alu_op = ALU_SRL;
					default: writes = 1'b0;
				endcase
			end
			OP_ADDIU: dec.alu_op = ALU_ADD;
			OP_SLTI: dec.alu_op = ALU_SLT;
			OP_ANDI: begin
				dec.alu_op = ALU_AND;
				dec.imm_value = {16'h0, inst[15:0]};
			end
			OP_ORI: begin
				dec.alu_op = ALU_OR;
				dec.imm_value = {16'h0, inst[15:0]};
			end
			OP_XORI: begin
				dec.alu_op = ALU_XOR;
				dec.imm_value = {16'h0, inst[15:0]};
			end
			OP_LUI: begin
				dec.alu_op = ALU_LUI;
				dec.imm_value = {inst[15:0], 16'h0};
			end
			// address is rs + imm through the adder
			OP_LW: begin
				dec.alu_op = ALU_ADD;
				dec.is_load = 1'b1;
			end
			OP_SW: begin
				dec.alu_op = ALU_ADD;
				dec.is_store = 1'b1;
				writes = 1'b0;
			end
			default: writes = 1'b0;
		endcase
		dec.reg_wen = writes && (dec.dest != '0);
	end

endmodule

// ==== src/mem_bus_if.sv ====
// four-phase req/ack memory link
// req up, ack up, req down, ack down
interface mem_bus_if;
	logic req;
	logic we;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic ack;
	logic [31:0] rdata;

	modport master (
		output req, we, addr, wdata,
		input ack, rdata
	);

	modport slave (
		input req, we, addr, wdata,
		output ack, rdata
	);

endinterface

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam word_t RESET_PC = 32'hBFC00000;
	localparam int FIFO_DEPTH = 4;

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI = 6'b001010;
	localparam logic [5:0] OP_ANDI = 6'b001100;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_XORI = 6'b001110;
	localparam logic [5:0] OP_LUI = 6'b001111;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_SW = 6'b101011;

	// special funct field
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_SLT = 6'b101010;

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_e;

	typedef struct packed {
		word_t inst;
		word_t pc;
	} inst_entry_t;

	typedef struct packed {
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		logic reg_wen;
		alu_op_e alu_op;
		logic use_imm;
		word_t imm_value;
		logic [4:0] shamt;
		logic is_load;
		logic is_store;
	} decoded_t;

	// kseg0 to 0x0, kseg1 to 0x1
	function automatic word_t map_addr(word_t vaddr);
		case (vaddr[31:28])
			4'h8: return {4'h0, vaddr[27:0]};
			4'hB: return {4'h1, vaddr[27:0]};
			default: return vaddr;
		endcase
	endfunction

	// shifts take the amount in a and the value in b
	function automatic word_t alu_exec(alu_op_e op, word_t a, word_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLT: return {31'b0, $signed(a) < $signed(b)};
			ALU_SLL: return b << a[4:0];
			ALU_SRL: return b >> a[4:0];
			ALU_LUI: return b;
			default: return '0;
		endcase
	endfunction

endpackage
